// File: rtl/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	typedef logic [31:0] uint32_t;
	typedef logic [4:0]  reg_addr_t;

	localparam int ROB_DEPTH = 8;
	typedef logic [$clog2(ROB_DEPTH)-1:0] rob_index_t;

	typedef enum logic [2:0] {
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_SLT,
		OP_SLL,
		OP_MUL
	} exec_op_t;

	typedef struct packed {
		logic       valid;
		rob_index_t reorder;
		uint32_t    data;
	} cdb_packet_t;

	typedef struct packed {
		logic      busy;
		logic      done;
		reg_addr_t dest;
		logic      write;
		uint32_t   value;
	} rob_entry_t;

	typedef struct packed {
		logic       busy;
		rob_index_t reorder;
	} reg_status_t;

	typedef enum logic {
		IDLE,
		WAIT_ACK
	} fetch_state_t;

	// Primary opcodes
	localparam logic [5:0] OPC_SPECIAL  = 6'b000000;
	localparam logic [5:0] OPC_SPECIAL2 = 6'b011100;
	localparam logic [5:0] OPC_ADDIU    = 6'b001001;
	localparam logic [5:0] OPC_LUI      = 6'b001111;

	// Function field codes
	localparam logic [5:0] FN_SLL  = 6'b000000;
	localparam logic [5:0] FN_ADDU = 6'b100001;
	localparam logic [5:0] FN_SUBU = 6'b100011;
	localparam logic [5:0] FN_AND  = 6'b100100;
	localparam logic [5:0] FN_OR   = 6'b100101;
	localparam logic [5:0] FN_XOR  = 6'b100110;
	localparam logic [5:0] FN_SLT  = 6'b101010;
	localparam logic [5:0] FN_MUL  = 6'b000010;

endpackage

`default_nettype wire

// File: rtl/exec_req_if.sv
`timescale 1ns/100ps
`default_nettype none

interface exec_req_if;
	import cpu_pkg::*;

	logic       valid;
	logic       ready;
	exec_op_t   op;
	uint32_t    src_a;
	uint32_t    src_b;
	logic [4:0] shamt;
	rob_index_t reorder;

	modport issue (
		output valid, op, src_a, src_b, shamt, reorder,
		input  ready
	);

	modport unit (
		input  valid, op, src_a, src_b, shamt, reorder,
		output ready
	);

endinterface

`default_nettype wire

// File: rtl/instr_fetch.sv
`timescale 1ns/100ps
`default_nettype none

module instr_fetch #(
	parameter int               FETCH_DEPTH = 4,
	parameter cpu_pkg::uint32_t RESET_PC    = 32'h0000_0000
) (
	input  logic             clk,
	input  logic             rst,
	output logic             wb_cyc,
	output logic             wb_stb,
	output cpu_pkg::uint32_t wb_adr,
	input  cpu_pkg::uint32_t wb_dat,
	input  logic             wb_ack,
	output cpu_pkg::uint32_t instr,
	output logic             instr_valid,
	input  logic             instr_pop
);
	import cpu_pkg::*;

	localparam int PTR_W = (FETCH_DEPTH > 1) ? $clog2(FETCH_DEPTH) : 1;
	localparam int CNT_W = $clog2(FETCH_DEPTH + 1);

	fetch_state_t     state;
	uint32_t          pc;
	uint32_t          buf_mem [FETCH_DEPTH];
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;
	logic [CNT_W-1:0] count;
	logic             push;
	logic             pop;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(FETCH_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	// Bus signals held for the whole read
	assign wb_cyc = (state == WAIT_ACK);
	assign wb_stb = (state == WAIT_ACK);
	assign wb_adr = pc;

	assign push        = (state == WAIT_ACK) && wb_ack;
	assign instr_valid = (count != '0);
	assign pop         = instr_pop && instr_valid;
	assign instr       = buf_mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (rst) begin
			state  <= IDLE;
			pc     <= RESET_PC;
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			case (state)
				// Only one read in flight, so room in the buffer is enough
				IDLE: if (count < CNT_W'(FETCH_DEPTH)) state <= WAIT_ACK;
				WAIT_ACK: begin
					if (wb_ack) begin
						state <= IDLE;
						pc    <= pc + 32'd4;
					end
				end
				default: state <= IDLE;
			endcase
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			count <= count + CNT_W'(push) - CNT_W'(pop);
		end
	end

	always_ff @(posedge clk) begin
		if (push)
			buf_mem[wr_ptr] <= wb_dat;
	end

endmodule

`default_nettype wire

// File: rtl/regfile.sv
`timescale 1ns/100ps
`default_nettype none

module regfile (
	input  logic                        clk,
	input  logic                        rst,
	input  cpu_pkg::reg_addr_t   [1:0]  raddr,
	output cpu_pkg::uint32_t     [1:0]  rdata,
	output cpu_pkg::reg_status_t [1:0]  rstatus,
	input  logic                        rename_we,
	input  cpu_pkg::reg_addr_t          rename_reg,
	input  cpu_pkg::rob_index_t         rename_tag,
	input  logic                        commit_we,
	input  cpu_pkg::reg_addr_t          commit_reg,
	input  cpu_pkg::rob_index_t         commit_tag,
	input  cpu_pkg::uint32_t            commit_data
);
	import cpu_pkg::*;

	uint32_t     regs   [32];
	reg_status_t status [32];

	always_comb begin
		for (int i = 0; i < 2; i++) begin
			rdata[i]   = (raddr[i] == '0) ? '0 : regs[raddr[i]];
			rstatus[i] = status[raddr[i]];
		end
	end

	always_ff @(posedge clk) begin
		if (commit_we && commit_reg != '0)
			regs[commit_reg] <= commit_data;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			status <= '{default: '0};
		end else begin
			// Younger rename keeps the register busy
			if (commit_we && status[commit_reg].reorder == commit_tag)
				status[commit_reg].busy <= 1'b0;
			if (rename_we && rename_reg != '0) begin
				status[rename_reg].busy    <= 1'b1;
				status[rename_reg].reorder <= rename_tag;
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/instr_issue.sv
`timescale 1ns/100ps
`default_nettype none

module instr_issue (
	input  cpu_pkg::uint32_t            instr,
	input  logic                        instr_valid,
	output logic                        instr_pop,
	output cpu_pkg::reg_addr_t   [1:0]  raddr,
	input  cpu_pkg::uint32_t     [1:0]  rdata,
	input  cpu_pkg::reg_status_t [1:0]  rstatus,
	output logic                        rename_we,
	output cpu_pkg::reg_addr_t          rename_reg,
	output cpu_pkg::rob_index_t         rename_tag,
	input  cpu_pkg::rob_index_t         rob_tail,
	input  logic                        rob_full,
	output logic                        alloc,
	output cpu_pkg::rob_entry_t         alloc_entry,
	output cpu_pkg::rob_index_t  [1:0]  rob_raddr,
	input  logic                 [1:0]  rob_rdone,
	input  cpu_pkg::uint32_t     [1:0]  rob_rdata,
	exec_req_if.issue                   alu,
	exec_req_if.issue                   mul
);
	import cpu_pkg::*;

	logic [5:0]    opcode;
	logic [5:0]    funct;
	exec_op_t      op;
	reg_addr_t     dest;
	logic          supported;
	logic          is_mul;
	logic          need_a;
	logic          need_b;
	logic          use_imm;
	uint32_t       imm;
	uint32_t [1:0] operand;
	logic    [1:0] operand_ok;
	uint32_t       src_a;
	uint32_t       src_b;
	logic          unit_ready;
	logic          fire;

	assign opcode   = instr[31:26];
	assign funct    = instr[5:0];
	assign raddr[0] = instr[25:21];
	assign raddr[1] = instr[20:16];

	always_comb begin
		op        = OP_ADD;
		dest      = instr[15:11];
		supported = 1'b1;
		is_mul    = 1'b0;
		need_a    = 1'b1;
		need_b    = 1'b1;
		use_imm   = 1'b0;
		imm       = '0;
		case (opcode)
			OPC_SPECIAL: begin
				case (funct)
					FN_ADDU: op = OP_ADD;
					FN_SUBU: op = OP_SUB;
					FN_AND:  op = OP_AND;
					FN_OR:   op = OP_OR;
					FN_XOR:  op = OP_XOR;
					FN_SLT:  op = OP_SLT;
					FN_SLL: begin
						op     = OP_SLL;
						need_a = 1'b0;
					end
					default: supported = 1'b0;
				endcase
			end
			OPC_SPECIAL2: begin
				op     = OP_MUL;
				is_mul = 1'b1;
				if (funct != FN_MUL)
					supported = 1'b0;
			end
			OPC_ADDIU: begin
				dest    = instr[20:16];
				need_b  = 1'b0;
				use_imm = 1'b1;
				imm     = {{16{instr[15]}}, instr[15:0]};
			end
			// LUI adds the shifted immediate to zero
			OPC_LUI: begin
				dest    = instr[20:16];
				need_a  = 1'b0;
				need_b  = 1'b0;
				use_imm = 1'b1;
				imm     = {instr[15:0], 16'h0000};
			end
			default: supported = 1'b0;
		endcase
	end

	// Busy sources come from the ROB once done
	always_comb begin
		for (int i = 0; i < 2; i++) begin
			rob_raddr[i]  = rstatus[i].reorder;
			operand_ok[i] = !rstatus[i].busy || rob_rdone[i];
			operand[i]    = rstatus[i].busy ? rob_rdata[i] : rdata[i];
		end
	end

	assign src_a      = need_a ? operand[0] : '0;
	assign src_b      = use_imm ? imm : operand[1];
	assign unit_ready = is_mul ? mul.ready : alu.ready;

	assign fire = instr_valid && !rob_full && (!supported ||
		(unit_ready && (operand_ok[0] || !need_a) && (operand_ok[1] || !need_b)));

	assign instr_pop   = fire;
	assign alloc       = fire;
	assign alloc_entry = '{busy: 1'b1, done: !supported, dest: dest,
		write: supported, value: '0};

	assign rename_we  = fire && supported && (dest != '0);
	assign rename_reg = dest;
	assign rename_tag = rob_tail;

	assign alu.valid   = fire && supported && !is_mul;
	assign alu.op      = op;
	assign alu.src_a   = src_a;
	assign alu.src_b   = src_b;
	assign alu.shamt   = instr[10:6];
	assign alu.reorder = rob_tail;

	assign mul.valid   = fire && supported && is_mul;
	assign mul.op      = op;
	assign mul.src_a   = src_a;
	assign mul.src_b   = src_b;
	assign mul.shamt   = instr[10:6];
	assign mul.reorder = rob_tail;

endmodule

`default_nettype wire

// File: rtl/alu_unit.sv
`timescale 1ns/100ps
`default_nettype none

module alu_unit (
	input  logic                clk,
	input  logic                rst,
	exec_req_if.unit            req,
	output cpu_pkg::cdb_packet_t cdb
);
	import cpu_pkg::*;

	uint32_t    result;
	logic       valid_q;
	rob_index_t tag_q;
	uint32_t    data_q;

	assign req.ready = 1'b1;

	always_comb begin
		case (req.op)
			OP_ADD:  result = req.src_a + req.src_b;
			OP_SUB:  result = req.src_a - req.src_b;
			OP_AND:  result = req.src_a & req.src_b;
			OP_OR:   result = req.src_a | req.src_b;
			OP_XOR:  result = req.src_a ^ req.src_b;
			OP_SLT:  result = {31'b0, $signed(req.src_a) < $signed(req.src_b)};
			OP_SLL:  result = req.src_b << req.shamt;
			default: result = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			valid_q <= 1'b0;
		else
			valid_q <= req.valid;
	end

	always_ff @(posedge clk) begin
		if (req.valid) begin
			tag_q  <= req.reorder;
			data_q <= result;
		end
	end

	assign cdb = '{valid: valid_q, reorder: tag_q, data: data_q};

endmodule

`default_nettype wire

// File: rtl/mul_unit.sv
`timescale 1ns/100ps
`default_nettype none

module mul_unit (
	input  logic                clk,
	input  logic                rst,
	exec_req_if.unit            req,
	output cpu_pkg::cdb_packet_t cdb
);
	import cpu_pkg::*;

	uint32_t    mcand;
	uint32_t    mplier;
	uint32_t    prod;
	rob_index_t tag;
	logic [4:0] cnt;
	logic       busy;
	logic       done;
	logic       accept;

	assign req.ready = !busy;
	assign accept    = req.valid && !busy;
	assign cdb       = '{valid: done, reorder: tag, data: prod};

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			done <= 1'b0;
			cnt  <= '0;
		end else begin
			done <= 1'b0;
			if (accept) begin
				busy <= 1'b1;
				cnt  <= '0;
			end else if (busy) begin
				cnt <= cnt + 1'b1;
				// Last of 32 steps
				if (cnt == 5'd31) begin
					busy <= 1'b0;
					done <= 1'b1;
				end
			end
		end
	end

	// Low word only, so the multiplicand may drop its top bits
	always_ff @(posedge clk) begin
		if (accept) begin
			mcand  <= req.src_a;
			mplier <= req.src_b;
			prod   <= '0;
			tag    <= req.reorder;
		end else if (busy) begin
			if (mplier[0])
				prod <= prod + mcand;
			mcand  <= mcand << 1;
			mplier <= mplier >> 1;
		end
	end

endmodule

`default_nettype wire

// File: rtl/rob.sv
`timescale 1ns/100ps
`default_nettype none

module rob (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       alloc,
	input  cpu_pkg::rob_entry_t        alloc_entry,
	output cpu_pkg::rob_index_t        tail,
	output logic                       full,
	input  cpu_pkg::cdb_packet_t       cdb_alu,
	input  cpu_pkg::cdb_packet_t       cdb_mul,
	input  cpu_pkg::rob_index_t [1:0]  raddr,
	output logic                [1:0]  rdone,
	output cpu_pkg::uint32_t    [1:0]  rdata,
	output logic                       commit_we,
	output cpu_pkg::reg_addr_t         commit_reg,
	output cpu_pkg::rob_index_t        commit_tag,
	output cpu_pkg::uint32_t           commit_data
);
	import cpu_pkg::*;

	localparam int CNT_W = $clog2(ROB_DEPTH + 1);

	rob_entry_t       entries [ROB_DEPTH];
	rob_index_t       head;
	logic [CNT_W-1:0] count;
	logic             retire;

	assign full = (count == CNT_W'(ROB_DEPTH));

	// Forwarding ports for the issue stage
	always_comb begin
		for (int i = 0; i < 2; i++) begin
			rdone[i] = entries[raddr[i]].done;
			rdata[i] = entries[raddr[i]].value;
		end
	end

	assign retire      = entries[head].busy && entries[head].done;
	assign commit_we   = retire && entries[head].write && (entries[head].dest != '0);
	assign commit_reg  = entries[head].dest;
	assign commit_tag  = head;
	assign commit_data = entries[head].value;

	always_ff @(posedge clk) begin
		if (rst) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
			for (int i = 0; i < ROB_DEPTH; i++) begin
				entries[i].busy <= 1'b0;
				entries[i].done <= 1'b0;
			end
		end else begin
			if (retire) begin
				entries[head].busy <= 1'b0;
				head               <= head + 1'b1;
			end
			// Both buses may report in one cycle
			if (cdb_alu.valid) begin
				entries[cdb_alu.reorder].done  <= 1'b1;
				entries[cdb_alu.reorder].value <= cdb_alu.data;
			end
			if (cdb_mul.valid) begin
				entries[cdb_mul.reorder].done  <= 1'b1;
				entries[cdb_mul.reorder].value <= cdb_mul.data;
			end
			if (alloc) begin
				entries[tail] <= alloc_entry;
				tail          <= tail + 1'b1;
			end
			count <= count + CNT_W'(alloc) - CNT_W'(retire);
		end
	end

endmodule

`default_nettype wire

// File: rtl/cpu_core.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_core #(
	parameter int               FETCH_DEPTH = 4,
	parameter cpu_pkg::uint32_t RESET_PC    = 32'h0000_0000
) (
	input  logic               clk,
	input  logic               rst,
	output logic               wb_cyc,
	output logic               wb_stb,
	output cpu_pkg::uint32_t   wb_adr,
	input  cpu_pkg::uint32_t   wb_dat,
	input  logic               wb_ack,
	output logic               commit_valid,
	output cpu_pkg::reg_addr_t commit_reg,
	output cpu_pkg::uint32_t   commit_data
);
	import cpu_pkg::*;

	// fetch to issue
	uint32_t fetch_instr;
	logic    fetch_valid;
	logic    fetch_pop;

	// register file ports
	reg_addr_t   [1:0] reg_raddr;
	uint32_t     [1:0] reg_rdata;
	reg_status_t [1:0] reg_status;
	logic              rename_we;
	reg_addr_t         rename_reg;
	rob_index_t        rename_tag;

	// ROB
	rob_index_t       rob_tail;
	logic             rob_full;
	logic             rob_alloc;
	rob_entry_t       rob_alloc_entry;
	rob_index_t [1:0] rob_raddr;
	logic       [1:0] rob_rdone;
	uint32_t    [1:0] rob_rdata;
	rob_index_t       commit_tag;

	// result buses
	cdb_packet_t cdb_alu;
	cdb_packet_t cdb_mul;

	exec_req_if alu_req ();
	exec_req_if mul_req ();

	instr_fetch #(
		.FETCH_DEPTH ( FETCH_DEPTH ),
		.RESET_PC    ( RESET_PC    )
	) instr_fetch_inst (
		.clk,
		.rst,
		.wb_cyc,
		.wb_stb,
		.wb_adr,
		.wb_dat,
		.wb_ack,
		.instr       ( fetch_instr ),
		.instr_valid ( fetch_valid ),
		.instr_pop   ( fetch_pop   )
	);

	regfile regfile_inst (
		.clk,
		.rst,
		.raddr       ( reg_raddr    ),
		.rdata       ( reg_rdata    ),
		.rstatus     ( reg_status   ),
		.rename_we,
		.rename_reg,
		.rename_tag,
		.commit_we   ( commit_valid ),
		.commit_reg,
		.commit_tag,
		.commit_data
	);

	instr_issue instr_issue_inst (
		.instr       ( fetch_instr     ),
		.instr_valid ( fetch_valid     ),
		.instr_pop   ( fetch_pop       ),
		.raddr       ( reg_raddr       ),
		.rdata       ( reg_rdata       ),
		.rstatus     ( reg_status      ),
		.rename_we,
		.rename_reg,
		.rename_tag,
		.rob_tail,
		.rob_full,
		.alloc       ( rob_alloc       ),
		.alloc_entry ( rob_alloc_entry ),
		.rob_raddr,
		.rob_rdone,
		.rob_rdata,
		.alu         ( alu_req         ),
		.mul         ( mul_req         )
	);

	alu_unit alu_unit_inst (
		.clk,
		.rst,
		.req ( alu_req ),
		.cdb ( cdb_alu )
	);

	mul_unit mul_unit_inst (
		.clk,
		.rst,
		.req ( mul_req ),
		.cdb ( cdb_mul )
	);

	rob rob_inst (
		.clk,
		.rst,
		.alloc       ( rob_alloc       ),
		.alloc_entry ( rob_alloc_entry ),
		.tail        ( rob_tail        ),
		.full        ( rob_full        ),
		.cdb_alu,
		.cdb_mul,
		.raddr       ( rob_raddr       ),
		.rdone       ( rob_rdone       ),
		.rdata       ( rob_rdata       ),
		.commit_we   ( commit_valid    ),
		.commit_reg,
		.commit_tag,
		.commit_data
	);

endmodule

`default_nettype wire

// File: sim/tb_cpu_core.sv
`timescale 1ns/100ps
`default_nettype none

module tb_cpu_core;
	import cpu_pkg::*;

	localparam int PROG_LEN    = 80;
	localparam int FETCH_DEPTH = 4;
	localparam int MAX_CYCLES  = PROG_LEN * 40 + 100;

	logic        clk;
	logic        rst;
	logic        wb_cyc;
	logic        wb_stb;
	uint32_t     wb_adr;
	uint32_t     wb_dat;
	logic        wb_ack;
	logic        commit_valid;
	reg_addr_t   commit_reg;
	uint32_t     commit_data;

	uint32_t     prog [PROG_LEN];
	int          prog_n;
	reg_addr_t   exp_reg [PROG_LEN];
	uint32_t     exp_data [PROG_LEN];
	int          exp_count;
	int          got_count;
	int          cycles;
	logic [31:0] rng;
	logic        in_cycle;
	logic        after_ack;
	int          wait_left;
	uint32_t     next_adr;

	cpu_core #(
		.FETCH_DEPTH ( FETCH_DEPTH ),
		.RESET_PC    ( 32'h0000_0000 )
	) u_cpu_core (
		.clk,
		.rst,
		.wb_cyc,
		.wb_stb,
		.wb_adr,
		.wb_dat,
		.wb_ack,
		.commit_valid,
		.commit_reg,
		.commit_data
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_rand();
		rng = xorshift(rng);
		return rng;
	endfunction

	function automatic reg_addr_t rand_reg(input int limit);
		return reg_addr_t'(next_rand() % limit);
	endfunction

	function automatic uint32_t enc_rtype(input logic [5:0] fn, input reg_addr_t rs,
		input reg_addr_t rt, input reg_addr_t rd, input logic [4:0] shamt);
		return {OPC_SPECIAL, rs, rt, rd, shamt, fn};
	endfunction

	function automatic uint32_t enc_itype(input logic [5:0] opc, input reg_addr_t rs,
		input reg_addr_t rt, input logic [15:0] imm);
		return {opc, rs, rt, imm};
	endfunction

	function automatic uint32_t enc_mul(input reg_addr_t rs, input reg_addr_t rt,
		input reg_addr_t rd);
		return {OPC_SPECIAL2, rs, rt, rd, 5'd0, FN_MUL};
	endfunction

	task automatic emit(input uint32_t word);
		prog[prog_n] = word;
		prog_n++;
	endtask

	task automatic build_program();
		logic [5:0] alu_fn [7];
		logic [5:0] fn;
		logic [4:0] shamt;
		uint32_t    v;
		alu_fn = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_SLT, FN_SLL};
		prog_n = 0;
		for (int i = 0; i < PROG_LEN; i++)
			prog[i] = '0;
		// Random constants in r1..r8
		for (int r = 1; r <= 8; r++) begin
			v = next_rand();
			emit(enc_itype(OPC_LUI, 5'd0, reg_addr_t'(r), v[31:16]));
			emit(enc_itype(OPC_ADDIU, reg_addr_t'(r), reg_addr_t'(r), v[15:0]));
		end
		// Random ALU mix with r0 sometimes as destination
		for (int i = 0; i < 16; i++) begin
			v     = next_rand();
			fn    = alu_fn[int'(v % 7)];
			shamt = (fn == FN_SLL) ? v[12:8] : 5'd0;
			emit(enc_rtype(fn, rand_reg(9), rand_reg(9), rand_reg(11), shamt));
		end
		// MUL overtaken by independent ALU work
		emit(enc_mul(5'd1, 5'd2, 5'd9));
		emit(enc_rtype(FN_ADDU, 5'd3, 5'd4, 5'd10, 5'd0));
		emit(enc_rtype(FN_XOR, 5'd5, 5'd6, 5'd11, 5'd0));
		emit(enc_rtype(FN_SLT, 5'd7, 5'd8, 5'd12, 5'd0));
		emit(enc_rtype(FN_OR, 5'd3, 5'd8, 5'd13, 5'd0));
		// Dependent chain through MUL, ALU and r0
		emit(enc_mul(5'd9, 5'd3, 5'd14));
		emit(enc_rtype(FN_ADDU, 5'd14, 5'd1, 5'd15, 5'd0));
		emit(enc_mul(5'd15, 5'd15, 5'd16));
		emit(enc_rtype(FN_SUBU, 5'd16, 5'd14, 5'd17, 5'd0));
		emit(enc_rtype(FN_SLL, 5'd0, 5'd17, 5'd18, 5'd3));
		emit(enc_rtype(FN_ADDU, 5'd0, 5'd18, 5'd19, 5'd0));
		emit(enc_itype(OPC_ADDIU, 5'd19, 5'd0, 16'h0005));
		emit(enc_rtype(FN_OR, 5'd0, 5'd19, 5'd20, 5'd0));
		emit(enc_itype(OPC_ADDIU, 5'd20, 5'd20, 16'hfffd));
		// One MUL at the head while the ROB fills behind it
		emit(enc_mul(5'd10, 5'd11, 5'd21));
		for (int k = 0; k < 8; k++) begin
			v = next_rand();
			emit(enc_itype(OPC_ADDIU, reg_addr_t'(1 + k), reg_addr_t'(22 + k), v[15:0]));
		end
		// Long MUL run
		for (int k = 1; k <= 10; k++)
			emit(enc_mul(reg_addr_t'(k), reg_addr_t'(k + 10), reg_addr_t'(20 + k)));
		emit(enc_rtype(FN_ADDU, 5'd21, 5'd30, 5'd31, 5'd0));
		emit(enc_rtype(FN_XOR, 5'd31, 5'd25, 5'd1, 5'd0));
		emit(enc_rtype(FN_SUBU, 5'd1, 5'd0, 5'd2, 5'd0));
	endtask

	// Sequential model of the program
	function automatic void build_expected();
		uint32_t   model [32];
		uint32_t   w;
		uint32_t   a;
		uint32_t   b;
		uint32_t   res;
		reg_addr_t dst;
		logic      writes;
		for (int r = 0; r < 32; r++)
			model[r] = '0;
		exp_count = 0;
		for (int i = 0; i < prog_n; i++) begin
			w      = prog[i];
			a      = model[w[25:21]];
			b      = model[w[20:16]];
			dst    = w[15:11];
			writes = 1'b1;
			res    = '0;
			case (w[31:26])
				OPC_SPECIAL: begin
					case (w[5:0])
						FN_ADDU: res = a + b;
						FN_SUBU: res = a - b;
						FN_AND:  res = a & b;
						FN_OR:   res = a | b;
						FN_XOR:  res = a ^ b;
						FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						FN_SLL:  res = b << w[10:6];
						default: writes = 1'b0;
					endcase
				end
				OPC_SPECIAL2: begin
					if (w[5:0] == FN_MUL)
						res = a * b;
					else
						writes = 1'b0;
				end
				OPC_ADDIU: begin
					dst = w[20:16];
					res = a + {{16{w[15]}}, w[15:0]};
				end
				OPC_LUI: begin
					dst = w[20:16];
					res = {w[15:0], 16'h0000};
				end
				default: writes = 1'b0;
			endcase
			if (writes && dst != '0) begin
				model[dst]          = res;
				exp_reg[exp_count]  = dst;
				exp_data[exp_count] = res;
				exp_count++;
			end
		end
	endfunction

	function automatic uint32_t mem_word(input uint32_t adr);
		int idx;
		idx = int'(adr[31:2]);
		if (idx < PROG_LEN)
			return prog[idx];
		else
			return '0;
	endfunction

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			fail_run($sformatf("error at %0t: %s is %b, expected %b", $time, name, got, exp));
	endtask

	task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
		if (got !== exp)
			fail_run($sformatf("error at %0t: %s is %0d, expected %0d", $time, name, got, exp));
	endtask

	task automatic check_data(input string name, input uint32_t got, input uint32_t exp);
		if (got !== exp)
			fail_run($sformatf("error at %0t: %s is %h, expected %h", $time, name, got, exp));
	endtask

	// Wishbone slave with 0 to 3 wait states per read
	always @(posedge clk) begin : wb_memory
		int d;
		if (rst) begin
			wb_ack    <= 1'b0;
			wb_dat    <= '0;
			in_cycle  <= 1'b0;
			after_ack <= 1'b0;
			wait_left <= 0;
			next_adr  <= 32'h0000_0000;
		end else begin
			// Address must hold until ack and then step by one word
			if (wb_cyc && wb_stb)
				check_data("wb_adr", wb_adr, next_adr);
			// Cycle held through the wait states and dropped for one cycle after ack
			if (in_cycle) begin
				check_flag("wb_cyc", wb_cyc, 1'b1);
				check_flag("wb_stb", wb_stb, 1'b1);
			end
			if (after_ack) begin
				check_flag("wb_cyc", wb_cyc, 1'b0);
				check_flag("wb_stb", wb_stb, 1'b0);
			end
			after_ack <= wb_ack;
			if (wb_ack) begin
				wb_ack   <= 1'b0;
				in_cycle <= 1'b0;
				next_adr <= next_adr + 32'd4;
			end else if (wb_cyc && wb_stb) begin
				if (!in_cycle) begin
					d = int'(next_rand() % 4);
					in_cycle  <= 1'b1;
					wait_left <= d - 1;
				end else begin
					d = wait_left;
					wait_left <= wait_left - 1;
				end
				if (d == 0) begin
					wb_ack <= 1'b1;
					wb_dat <= mem_word(wb_adr);
				end
			end
		end
	end

	always @(negedge clk) begin
		if (!rst && commit_valid) begin
			if (got_count >= exp_count) begin
				fail_run($sformatf("unexpected commit to r%0d after all %0d expected commits",
					commit_reg, exp_count));
			end else begin
				check_reg("commit_reg", commit_reg, exp_reg[got_count]);
				check_data("commit_data", commit_data, exp_data[got_count]);
				got_count++;
			end
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES)
			fail_run($sformatf("timeout after %0d cycles: commit %0d of %0d never arrived",
				cycles, got_count + 1, exp_count));
	end

	initial begin
		rst       = 1'b1;
		wb_ack    = 1'b0;
		wb_dat    = '0;
		got_count = 0;
		cycles    = 0;
		rng       = 32'hb924;
		build_program();
		build_expected();
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		wait (got_count == exp_count);
		// Quiet period to catch extra commits
		repeat (50) @(posedge clk);
		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
rtl/cpu_pkg.sv
rtl/exec_req_if.sv
rtl/instr_fetch.sv
rtl/regfile.sv
rtl/instr_issue.sv
rtl/alu_unit.sv
rtl/mul_unit.sv
rtl/rob.sv
rtl/cpu_core.sv
sim/tb_cpu_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_cpu_core
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
SOURCES   := $(wildcard rtl/*.sv) $(wildcard sim/*.sv)
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): list.f $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f list.f

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
